// ==== src/csr_consts.svh ====
// constants of the CSR path; RV32 only, no 64-bit counters
// CSR_UNMAPPED_A must stay outside the implemented address set

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CSR_XLEN        32          // data width
`define CSR_FIFO_DEPTH  4           // request FIFO entries

// machine mode CSR addresses
`define MCYCLE_A        12'hB00
`define MISA_A          12'h301
`define MSCRATCH_A      12'h340
`define MTVEC_A         12'h305
`define MEPC_A          12'h341
`define MCAUSE_A        12'h342
`define MTVAL_A         12'h343

// address given to bad funct3 requests, flagged by the CSR file
`define CSR_UNMAPPED_A  12'hFFF

// misa: MXL = 1 (32 bit), extension I only
`define MISA_V          32'h4000_0100

`endif

// ==== src/csr_pkg.sv ====
// types shared by the CSR path; widths follow CSR_XLEN from the consts header
// only the six SYSTEM CSR funct3 codes are meaningful, the rest decode as illegal

`include "csr_consts.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        CSR_F3_ILL = 3'b000,            // also stands for 3'b100
        CSRRW      = 3'b001,
        CSRRS      = 3'b010,
        CSRRC      = 3'b011,
        CSRRWI     = 3'b101,
        CSRRSI     = 3'b110,
        CSRRCI     = 3'b111
    } csr_funct3_e;

    typedef enum logic [1:0] {
        CSR_NONE = 2'b00,               // read only, no write
        CSR_WR   = 2'b01,               // old <= data
        CSR_SET  = 2'b10,               // old | data
        CSR_CLR  = 2'b11                // old & ~data
    } csr_cmd_e;

    typedef struct packed {
        csr_funct3_e                funct3;
        logic [11:0]                addr;
        logic [4:0]                 rd;
        logic [4:0]                 rs1;    // also the uimm of the I forms
        logic [`CSR_XLEN-1:0]       rs1_val;
    } csr_instr_t;

    typedef struct packed {
        logic [11:0]                addr;
        csr_cmd_e                   cmd;
        logic [`CSR_XLEN-1:0]       wdata;
        logic                       rd_en;  // old value wanted
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0]       rdata;
        logic                       rd_en;
        logic                       illegal;
    } csr_rsp_t;

endpackage

// ==== src/csr_decode.sv ====
// turns raw CSR instruction fields into a request, one cycle latency
// bad funct3 leaves as a read of CSR_UNMAPPED_A so the CSR file flags it

`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_decode
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    instr_valid_i,
    output logic                    instr_ready_o,
    input  csr_pkg::csr_instr_t     instr_i,
    output logic                    req_valid_o,
    input  logic                    req_ready_i,
    output csr_pkg::csr_req_t       req_o
);

    import csr_pkg::*;

    csr_req_t   dec_req;            // combinational decode result
    csr_req_t   req_q;              // output slot
    logic       req_valid_q;
    logic       accept;
    logic       rs1_zero;           // no write for set/clear forms
    logic       rd_zero;            // no read for write forms

    assign rs1_zero      = (instr_i.rs1 == 5'd0);
    assign rd_zero       = (instr_i.rd == 5'd0);
    assign instr_ready_o = !req_valid_q || req_ready_i;    // slot empty or draining
    assign accept        = instr_valid_i && instr_ready_o;

    always_comb
    begin
        dec_req.addr  = instr_i.addr;
        dec_req.cmd   = CSR_NONE;
        dec_req.wdata = instr_i.rs1_val;
        dec_req.rd_en = 1'b1;
        case (instr_i.funct3)
            CSRRW   : begin dec_req.cmd = CSR_WR; dec_req.rd_en = !rd_zero; end
            CSRRS   : dec_req.cmd = rs1_zero ? CSR_NONE : CSR_SET;
            CSRRC   : dec_req.cmd = rs1_zero ? CSR_NONE : CSR_CLR;
            CSRRWI  : begin dec_req.cmd = CSR_WR; dec_req.rd_en = !rd_zero; end
            CSRRSI  : dec_req.cmd = rs1_zero ? CSR_NONE : CSR_SET;
            CSRRCI  : dec_req.cmd = rs1_zero ? CSR_NONE : CSR_CLR;
            default : dec_req.addr = `CSR_UNMAPPED_A;      // illegal funct3
        endcase
        // immediate forms: uimm zero-extended
        if (instr_i.funct3 inside {CSRRWI, CSRRSI, CSRRCI})
            dec_req.wdata = {{(`CSR_XLEN-5){1'b0}}, instr_i.rs1};
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            req_valid_q <= 1'b0;
        else if (accept)
            req_valid_q <= 1'b1;
        else if (req_ready_i)
            req_valid_q <= 1'b0;    // taken, nothing new
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            req_q <= dec_req;
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;

endmodule

// ==== src/csr_req_fifo.sv ====
// circular request FIFO, CSR_FIFO_DEPTH entries, storage has no reset
// push while full is taken only when a pop happens in the same cycle

`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_req_fifo
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  csr_pkg::csr_req_t       in_i,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output csr_pkg::csr_req_t       out_o
);

    import csr_pkg::*;

    localparam int PW = (`CSR_FIFO_DEPTH > 1) ? $clog2(`CSR_FIFO_DEPTH) : 1;
    localparam int CW = $clog2(`CSR_FIFO_DEPTH + 1);

    csr_req_t           mem [`CSR_FIFO_DEPTH];
    logic [PW-1:0]      wr_ptr;
    logic [PW-1:0]      rd_ptr;
    logic [CW-1:0]      count;      // occupancy
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    assign full        = (count == CW'(`CSR_FIFO_DEPTH));
    assign empty       = (count == '0);
    assign out_valid_o = !empty;
    assign in_ready_o  = !full || out_ready_i;     // full, but an entry leaves now
    assign pop         = out_valid_o && out_ready_i;
    assign push        = in_valid_i && in_ready_o;
    assign out_o       = mem[rd_ptr];              // head entry, from storage

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(`CSR_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(`CSR_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_i;
    end

endmodule

// ==== src/csr_file.sv ====
// machine CSR storage; no trap entry, mepc/mcause/mtval change only by request
// response carries the value from before the write, zero data when illegal
// misa is a constant, any write command to it is illegal

`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_file
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  csr_pkg::csr_req_t       req_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output csr_pkg::csr_rsp_t       rsp_o,
    output logic [`CSR_XLEN-1:0]    mtvec_o
);

    import csr_pkg::*;

    logic [`CSR_XLEN-1:0]   mcycle;     // cycle counter, low half
    logic [`CSR_XLEN-1:0]   mscratch;
    logic [`CSR_XLEN-1:0]   mtvec;      // trap base
    logic [`CSR_XLEN-1:0]   mepc;
    logic [`CSR_XLEN-1:0]   mcause;
    logic [`CSR_XLEN-1:0]   mtval;

    logic [`CSR_XLEN-1:0]   old_val;    // selected by address
    logic [`CSR_XLEN-1:0]   new_val;    // after write/set/clear
    logic                   mapped;
    logic                   illegal;
    logic                   accept;
    logic                   wr_en;      // write at this edge
    logic                   rsp_valid_q;
    csr_rsp_t               rsp_q;

    assign req_ready_o = !rsp_valid_q || rsp_ready_i;  // pending one leaves now
    assign accept      = req_valid_i && req_ready_o;

    // address decode, old value
    always_comb
    begin
        mapped  = 1'b1;
        old_val = '0;
        case (req_i.addr)
            `MCYCLE_A   : old_val = mcycle;
            `MISA_A     : old_val = `MISA_V;
            `MSCRATCH_A : old_val = mscratch;
            `MTVEC_A    : old_val = mtvec;
            `MEPC_A     : old_val = mepc;
            `MCAUSE_A   : old_val = mcause;
            `MTVAL_A    : old_val = mtval;
            default     : mapped = 1'b0;
        endcase
    end

    assign illegal = !mapped || ((req_i.addr == `MISA_A) && (req_i.cmd != CSR_NONE));
    assign wr_en   = accept && !illegal && (req_i.cmd != CSR_NONE);

    // read-modify-write
    always_comb
    begin
        case (req_i.cmd)
            CSR_WR  : new_val = req_i.wdata;
            CSR_SET : new_val = old_val | req_i.wdata;
            CSR_CLR : new_val = old_val & ~req_i.wdata;
            default : new_val = old_val;            // read only
        endcase
    end

    // mcycle runs freely, a write wins over the increment
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            mcycle <= '0;
        else if (wr_en && (req_i.addr == `MCYCLE_A))
            mcycle <= new_val;
        else
            mcycle <= mcycle + 1'b1;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end
        else if (wr_en)
        begin
            case (req_i.addr)
                `MSCRATCH_A : mscratch <= new_val;
                `MTVEC_A    : mtvec    <= new_val;
                `MEPC_A     : mepc     <= new_val;
                `MCAUSE_A   : mcause   <= new_val;
                `MTVAL_A    : mtval    <= new_val;
                default     : ;                      // mcycle handled above
            endcase
        end
    end

    // response slot
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            rsp_valid_q <= 1'b0;
        else if (accept)
            rsp_valid_q <= 1'b1;
        else if (rsp_ready_i)
            rsp_valid_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rsp_q.rdata   <= illegal ? '0 : old_val;
            rsp_q.rd_en   <= req_i.rd_en;
            rsp_q.illegal <= illegal;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;
    assign mtvec_o     = mtvec;        // live value

endmodule

// ==== src/csr_unit_top.sv ====
// CSR path: decode -> request FIFO -> CSR file
// three cycles from instruction accept to response without back-pressure

`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_top
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    instr_valid_i,
    output logic                    instr_ready_o,
    input  csr_pkg::csr_instr_t     instr_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output csr_pkg::csr_rsp_t       rsp_o,
    output logic [`CSR_XLEN-1:0]    mtvec_o
);

    import csr_pkg::*;

    logic       dec_valid;      // decode -> FIFO
    logic       dec_ready;
    csr_req_t   dec_req;
    logic       fifo_valid;     // FIFO -> CSR file
    logic       fifo_ready;
    csr_req_t   fifo_req;

    csr_decode u_decode
    (
        .clk            (clk),
        .resetn         (resetn),
        .instr_valid_i  (instr_valid_i),
        .instr_ready_o  (instr_ready_o),
        .instr_i        (instr_i),
        .req_valid_o    (dec_valid),
        .req_ready_i    (dec_ready),
        .req_o          (dec_req)
    );

    csr_req_fifo u_fifo
    (
        .clk            (clk),
        .resetn         (resetn),
        .in_valid_i     (dec_valid),
        .in_ready_o     (dec_ready),
        .in_i           (dec_req),
        .out_valid_o    (fifo_valid),
        .out_ready_i    (fifo_ready),
        .out_o          (fifo_req)
    );

    csr_file u_csr_file
    (
        .clk            (clk),
        .resetn         (resetn),
        .req_valid_i    (fifo_valid),
        .req_ready_o    (fifo_ready),
        .req_i          (fifo_req),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .rsp_o          (rsp_o),
        .mtvec_o        (mtvec_o)
    );

endmodule

// ==== bench/csr_unit_assert.sv ====
// handshake and reset checks on csr_unit_top, attached by bind
// reset properties look at the first rising edge after release

`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_assert
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    instr_ready_i,
    input  logic                    rsp_valid_i,
    input  logic                    rsp_ready_i,
    input  csr_pkg::csr_rsp_t       rsp_i,
    input  logic [`CSR_XLEN-1:0]    mtvec_i
);

    rsp_hold: assert property (@(posedge clk) disable iff (!resetn)
        (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i)))
        else $error("response dropped or changed while stalled");

    ready_after_reset: assert property (@(posedge clk) $rose(resetn) |-> instr_ready_i)
        else $error("instruction port not ready after reset");

    rsp_idle_after_reset: assert property (@(posedge clk) $rose(resetn) |-> !rsp_valid_i)
        else $error("response valid right after reset");

    // mtvec is written at the accepting edge, its response is valid from then
    mtvec_with_rsp: assert property (@(posedge clk) disable iff (!resetn)
        $changed(mtvec_i) |-> rsp_valid_i)
        else $error("mtvec changed without a response");

endmodule

bind csr_unit_top csr_unit_assert u_assert
(
    .clk            (clk),
    .resetn         (resetn),
    .instr_ready_i  (instr_ready_o),
    .rsp_valid_i    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_i          (rsp_o),
    .mtvec_i        (mtvec_o)
);

// ==== bench/csr_unit_tb.sv ====
// runs bench/csr_cases.txt through csr_unit_top, run from the project root
// mcycle lines (check flag 1) only need rdata above a bound, the rest match exactly
// response ready toggles randomly, so several instructions stay in flight

`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_tb;

    import csr_pkg::*;

    localparam int TIMEOUT = 200;               // cycles per wait

    logic                   clk;
    logic                   resetn;
    logic                   instr_valid_i;
    logic                   instr_ready_o;
    csr_instr_t             instr_i;
    logic                   rsp_valid_o;
    logic                   rsp_ready_i;
    csr_rsp_t               rsp_o;
    logic [`CSR_XLEN-1:0]   mtvec_o;

    csr_rsp_t               exp_rsp_q[$];       // expected, issue order
    logic                   exp_loose_q[$];     // mcycle read, bound only
    logic [`CSR_XLEN-1:0]   exp_mtvec_q[$];     // mtvec after that case
    int                     fail_cnt;           // wrong values
    int                     stray_cnt;          // responses nobody asked for
    int                     other_cnt;          // timeouts, file trouble
    int                     sent_cnt;
    int                     rcvd_cnt;
    integer                 seed;

    csr_unit_top UUT
    (
        .clk            (clk),
        .resetn         (resetn),
        .instr_valid_i  (instr_valid_i),
        .instr_ready_o  (instr_ready_o),
        .instr_i        (instr_i),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .rsp_o          (rsp_o),
        .mtvec_o        (mtvec_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    // rd_en is low only for a write form with rd = x0
    function automatic logic expect_rd_en(input logic [2:0] f3, input logic [4:0] rd);
        return !(((f3 == 3'd1) || (f3 == 3'd5)) && (rd == 5'd0));
    endfunction

    // mtvec after one instruction, from the RISC-V CSR rules
    function automatic logic [`CSR_XLEN-1:0] next_mtvec(input logic [`CSR_XLEN-1:0] cur,
        input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] rs1,
        input logic [`CSR_XLEN-1:0] val);
        logic [`CSR_XLEN-1:0] opnd;
        logic [`CSR_XLEN-1:0] res;
        opnd = f3[2] ? {{(`CSR_XLEN-5){1'b0}}, rs1} : val;   // uimm forms
        res  = cur;
        if (addr == `MTVEC_A)
        begin
            case (f3)
                3'd1, 3'd5 : res = opnd;
                3'd2, 3'd6 : res = (rs1 == 5'd0) ? cur : (cur | opnd);
                3'd3, 3'd7 : res = (rs1 == 5'd0) ? cur : (cur & ~opnd);
                default    : res = cur;         // bad funct3
            endcase
        end
        return res;
    endfunction

    task automatic compare_rsp(input csr_rsp_t got, input csr_rsp_t want, input logic loose);
        if (got.rd_en !== want.rd_en)
        begin
            $display("Fail: rsp_o.rd_en = %h, expected %h", got.rd_en, want.rd_en);
            fail_cnt++;
        end
        if (got.illegal !== want.illegal)
        begin
            $display("Fail: rsp_o.illegal = %h, expected %h", got.illegal, want.illegal);
            fail_cnt++;
        end
        if (loose ? !(got.rdata > want.rdata) : (got.rdata !== want.rdata))
        begin
            $display("Fail: rsp_o.rdata = %h, expected %s%h", got.rdata,
                     loose ? "above " : "", want.rdata);
            fail_cnt++;
        end
    endtask

    task automatic compare_mtvec(input logic [`CSR_XLEN-1:0] got,
        input logic [`CSR_XLEN-1:0] want);
        if (got !== want)
        begin
            $display("Fail: mtvec_o = %h, expected %h", got, want);
            fail_cnt++;
        end
    endtask

    // holds valid and data until ready, sampled mid low phase
    task automatic send_instr(input csr_instr_t instr, output logic ok);
        int wait_cnt;
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        wait_cnt      = 0;
        ok            = 1'b0;
        while (!ok && (wait_cnt < TIMEOUT))
        begin
            #5;
            if (instr_ready_o)
                ok = 1'b1;                      // taken at the next rising edge
            else
            begin
                @(negedge clk);
                wait_cnt++;
            end
        end
        if (ok)
            sent_cnt++;
        else
        begin
            $display("Error: instruction %0d was not accepted within %0d cycles",
                     sent_cnt, TIMEOUT);
            other_cnt++;
        end
    endtask

    // response side, random ready and in-order checking
    initial
    begin : collect
        csr_rsp_t               want;
        logic                   loose;
        logic [`CSR_XLEN-1:0]   want_mtvec;
        logic [`CSR_XLEN-1:0]   last_mcycle;
        logic [31:0]            rnd;
        seed        = 47;
        rsp_ready_i = 1'b0;
        fail_cnt    = 0;
        stray_cnt   = 0;
        rcvd_cnt    = 0;
        last_mcycle = '0;
        forever
        begin
            @(negedge clk);
            rnd         = $random(seed);
            rsp_ready_i = rnd[0];               // about half the cycles stalled
            #5;
            if (rsp_valid_o && rsp_ready_i)
            begin
                if (exp_rsp_q.size() == 0)
                begin
                    $display("Error: a response arrived with no instruction outstanding");
                    stray_cnt++;
                end
                else
                begin
                    want       = exp_rsp_q.pop_front();
                    loose      = exp_loose_q.pop_front();
                    want_mtvec = exp_mtvec_q.pop_front();
                    if (loose && (last_mcycle > want.rdata))
                        want.rdata = last_mcycle;       // reads strictly increase
                    compare_rsp(rsp_o, want, loose);
                    compare_mtvec(mtvec_o, want_mtvec);
                    if (loose)
                        last_mcycle = rsp_o.rdata;
                end
                rcvd_cnt++;
            end
        end
    end

    initial
    begin : drive
        int                     fd;
        int                     n;
        int                     wait_cnt;
        logic                   ok;
        logic [31:0]            f3;
        logic [31:0]            addr;
        logic [31:0]            rd;
        logic [31:0]            rs1;
        logic [31:0]            e_ill;
        logic [31:0]            chk;
        logic [`CSR_XLEN-1:0]   val;
        logic [`CSR_XLEN-1:0]   e_data;
        logic [`CSR_XLEN-1:0]   mtvec_model;
        logic [8*160-1:0]       skip;
        csr_instr_t             instr;
        csr_rsp_t               want;
        resetn        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        other_cnt     = 0;
        sent_cnt      = 0;
        ok            = 1'b1;
        mtvec_model   = '0;
        repeat (3) @(negedge clk);
        resetn = 1'b1;

        fd = $fopen("bench/csr_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Error: cannot open the case file bench/csr_cases.txt");
            other_cnt++;
        end
        while ((fd != 0) && ok && !$feof(fd))
        begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h\n",
                        f3, addr, rd, rs1, val, e_data, e_ill, chk);
            if (n != 8)
            begin
                n = $fgets(skip, fd);           // comment or blank line
                continue;
            end
            instr.funct3  = csr_funct3_e'(f3[2:0]);
            instr.addr    = addr[11:0];
            instr.rd      = rd[4:0];
            instr.rs1     = rs1[4:0];
            instr.rs1_val = val;
            want.rdata    = e_data;
            want.rd_en    = expect_rd_en(f3[2:0], rd[4:0]);
            want.illegal  = e_ill[0];
            mtvec_model   = next_mtvec(mtvec_model, f3[2:0], addr[11:0], rs1[4:0], val);
            exp_rsp_q.push_back(want);
            exp_loose_q.push_back(chk[0]);
            exp_mtvec_q.push_back(mtvec_model);
            send_instr(instr, ok);
        end
        if (fd != 0)
            $fclose(fd);
        @(negedge clk);
        instr_valid_i = 1'b0;

        wait_cnt = 0;
        while ((rcvd_cnt < sent_cnt) && (wait_cnt < TIMEOUT))
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (rcvd_cnt < sent_cnt)
        begin
            $display("Error: %0d responses still missing after %0d cycles",
                     sent_cnt - rcvd_cnt, TIMEOUT);
            other_cnt++;
        end

        $display("Summary: %0d value errors, %0d stray responses, %0d other errors, %0d of %0d responses",
                 fail_cnt, stray_cnt, other_cnt, rcvd_cnt, sent_cnt);
        if ((fail_cnt == 0) && (stray_cnt == 0) && (other_cnt == 0) && (sent_cnt > 0))
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== bench/csr_cases.txt ====
# funct3 addr rd rs1 rs1_val exp_rdata exp_illegal check, all hex
# check 1: mcycle read, exp_rdata is a lower bound (exclusive)
1 340 01 05 0000F0F0 00000000 0 0
2 340 01 06 0000000F 0000F0F0 0 0
3 340 01 07 000000F0 0000F0FF 0 0
2 340 01 00 FFFFFFFF 0000F00F 0 0
1 305 01 05 00001000 00000000 0 0
6 305 01 03 DEADBEEF 00001000 0 0
7 305 01 01 DEADBEEF 00001003 0 0
5 341 00 1F 00000000 00000000 0 0
2 341 01 00 00000000 0000001F 0 0
7 305 01 00 FFFFFFFF 00001002 0 0
2 301 01 00 00000000 40000100 0 0
1 301 01 05 12345678 00000000 1 0
2 301 01 00 00000000 40000100 0 0
1 7C0 01 05 AAAAAAAA 00000000 1 0
0 340 01 05 55555555 00000000 1 0
2 340 01 00 00000000 0000F00F 0 0
2 B00 01 00 00000000 00000000 0 1
1 B00 01 05 00100000 00000000 0 1
2 305 01 00 00000000 00001002 0 0
2 B00 01 00 00000000 00100000 0 1
2 B00 01 00 00000000 00100000 0 1

// ==== csr_unit.f ====
+incdir+src
src/csr_pkg.sv
src/csr_decode.sv
src/csr_req_fifo.sv
src/csr_file.sv
src/csr_unit_top.sv
bench/csr_unit_assert.sv
bench/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = csr_unit_tb
FLIST     = csr_unit.f
OBJDIR    = obj_dir
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
